// ==== source/mem_bus_pkg.sv ====
package mem_bus_pkg;

    localparam int xlen = 32;
    localparam int block_bytes = 8;
    localparam int block_offset_bits = 3; // log2 of block_bytes

    typedef logic [xlen-1:0] mem_addr_t;
    typedef logic [8*block_bytes-1:0] mem_block_t;

    // zero on the response lines means the command was not taken
    typedef logic [3:0] mem_tag_t;

    typedef enum logic [1:0] {
        bus_none  = 2'h0,
        bus_load  = 2'h1,
        bus_store = 2'h2
    } bus_command_t;

endpackage

// ==== source/dcache_pkg.sv ====
package dcache_pkg;

    localparam int line_addr_bits = mem_bus_pkg::xlen - mem_bus_pkg::block_offset_bits;

    typedef logic [line_addr_bits-1:0] line_addr_t;
    typedef logic [mem_bus_pkg::block_offset_bits-1:0] block_offset_t;

    typedef enum logic [1:0] {
        size_byte = 2'h0,
        size_half = 2'h1,
        size_word = 2'h2
    } mem_size_t;

    typedef enum logic {
        mem_read  = 1'b0,
        mem_write = 1'b1
    } mem_op_t;

    typedef enum logic [2:0] {
        st_ready,
        st_wait_mshr,   // miss seen, waiting for room in the MSHR table
        st_wait,        // read outstanding
        st_flush,
        st_flush_done
    } dc_state_t;

    typedef struct packed {
        logic                  valid;
        mem_op_t               mem_op;
        mem_size_t             size;
        mem_bus_pkg::mem_addr_t addr;
        logic [31:0]           write_data;
    } dcache_request_t;

    typedef struct packed {
        logic        valid;
        logic [31:0] reg_data;
    } dcache_response_t;

    typedef struct packed {
        logic                   valid;
        logic                   dirty;
        line_addr_t             line_addr; // full line address, not just the tag
        mem_bus_pkg::mem_block_t block;
    } cache_line_t;

    typedef struct packed {
        logic                   valid;
        mem_op_t                mem_op;
        logic                   issued;
        mem_bus_pkg::mem_tag_t  mem_tag;
        line_addr_t             line_addr;
        mem_bus_pkg::mem_block_t block;
    } mshr_entry_t;

    typedef struct packed {
        logic                   valid;
        line_addr_t             line_addr;
        mem_bus_pkg::mem_block_t block;
    } refill_t;

    typedef struct packed {
        logic                   valid;
        line_addr_t             line_addr;
        mem_bus_pkg::mem_block_t block;
    } writeback_t;

    // zero-extended load data from the addressed lane
    function automatic logic [31:0] extract_data(mem_bus_pkg::mem_block_t block,
                                                 mem_size_t size, block_offset_t offset);
        case (size)
            size_byte: return {24'h0, block[offset*8 +: 8]};
            size_half: return {16'h0, block[offset[2:1]*16 +: 16]};
            default:   return block[offset[2]*32 +: 32];
        endcase
    endfunction

    function automatic mem_bus_pkg::mem_block_t merge_data(mem_bus_pkg::mem_block_t block,
                                                           mem_size_t size,
                                                           block_offset_t offset,
                                                           logic [31:0] data);
        mem_bus_pkg::mem_block_t merged;
        merged = block;
        case (size)
            size_byte: merged[offset*8 +: 8] = data[7:0];
            size_half: merged[offset[2:1]*16 +: 16] = data[15:0];
            default:   merged[offset[2]*32 +: 32] = data;
        endcase
        return merged;
    endfunction

endpackage

// ==== source/dcache_control.sv ====
`timescale 1ns/1ps

module dcache_control #(
    parameter int num_lines = 16,
    parameter int count_bits = 3
) (
    input  logic                          clock,
    input  logic                          reset,
    input  dcache_pkg::dcache_request_t   dcache_request,
    input  logic                          done,
    input  logic                          hit,
    input  mem_bus_pkg::mem_block_t       hit_block,
    input  dcache_pkg::refill_t           refill,
    input  logic [count_bits-1:0]         free_count,
    input  logic                          mshr_empty,
    output dcache_pkg::dcache_request_t   lookup_request,
    output logic                          miss_alloc,
    output mem_bus_pkg::mem_addr_t        miss_line_addr,
    output logic                          flush_valid,
    output logic [$clog2(num_lines)-1:0]  flush_index,
    output logic                          stall,
    output dcache_pkg::dcache_response_t  dcache_response,
    output logic                          flush_finished
);
    localparam int index_bits = $clog2(num_lines);
    localparam int off = mem_bus_pkg::block_offset_bits;

    dcache_pkg::dc_state_t state, next_state;
    dcache_pkg::dcache_request_t waiting;     // the miss being served
    dcache_pkg::dcache_response_t next_response;
    logic [index_bits-1:0] sweep_index;
    logic sweep_done;
    logic new_miss;
    logic refill_match;
    logic room_for_miss;

    assign stall = state != dcache_pkg::st_ready;
    assign flush_finished = state == dcache_pkg::st_flush_done;

    // outside st_ready the array sees the waiting request, so a store miss merges on refill
    assign lookup_request = (state == dcache_pkg::st_ready) ? dcache_request : waiting;

    assign new_miss = state == dcache_pkg::st_ready && !done && dcache_request.valid && !hit;
    assign refill_match = state == dcache_pkg::st_wait && refill.valid
                          && refill.line_addr == waiting.addr[mem_bus_pkg::xlen-1:off];
    // the read takes one entry, a dirty eviction on refill may take another
    assign room_for_miss = free_count >= 2;

    assign miss_alloc = next_state == dcache_pkg::st_wait && state != dcache_pkg::st_wait;
    assign miss_line_addr = (state == dcache_pkg::st_ready) ? dcache_request.addr : waiting.addr;

    assign flush_valid = state == dcache_pkg::st_flush && !sweep_done && free_count != '0;
    assign flush_index = sweep_index;

    always_comb begin
        next_state = state;
        case (state)
            dcache_pkg::st_ready: begin
                if (done)
                    next_state = dcache_pkg::st_flush;
                else if (new_miss)
                    next_state = room_for_miss ? dcache_pkg::st_wait : dcache_pkg::st_wait_mshr;
            end
            dcache_pkg::st_wait_mshr: if (room_for_miss) next_state = dcache_pkg::st_wait;
            dcache_pkg::st_wait:      if (refill_match) next_state = dcache_pkg::st_ready;
            dcache_pkg::st_flush:     if (sweep_done && mshr_empty) next_state = dcache_pkg::st_flush_done;
            default:                  next_state = state;
        endcase
    end

    always_comb begin
        next_response = '0;
        if (state == dcache_pkg::st_ready && dcache_request.valid && hit) begin
            next_response.valid = 1'b1;
            if (dcache_request.mem_op == dcache_pkg::mem_read)
                next_response.reg_data = dcache_pkg::extract_data(hit_block,
                    dcache_request.size, dcache_request.addr[off-1:0]);
        end else if (refill_match) begin
            next_response.valid = 1'b1;
            if (waiting.mem_op == dcache_pkg::mem_read)
                next_response.reg_data = dcache_pkg::extract_data(refill.block,
                    waiting.size, waiting.addr[off-1:0]);
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            state           <= dcache_pkg::st_ready;
            waiting         <= '0;
            sweep_index     <= '0;
            sweep_done      <= 1'b0;
            dcache_response <= '0;
        end else begin
            state           <= next_state;
            dcache_response <= next_response;
            if (new_miss)
                waiting <= dcache_request;
            else if (refill_match)
                waiting <= '0;
            if (flush_valid) begin
                sweep_index <= sweep_index + 1'b1;
                if (sweep_index == index_bits'(num_lines - 1))
                    sweep_done <= 1'b1; // last line handed to the array
            end
        end
    end

    // only one read is outstanding, so every refill belongs to the waiting miss
    refill_for_waiting: assert property (@(posedge clock) disable iff (reset)
        refill.valid |-> state == dcache_pkg::st_wait
        && refill.line_addr == waiting.addr[mem_bus_pkg::xlen-1:off]);

endmodule

// ==== source/main_cache_array.sv ====
`timescale 1ns/1ps

module main_cache_array #(
    parameter int num_lines = 16
) (
    input  logic                         clock,
    input  logic                         reset,
    input  dcache_pkg::dcache_request_t  lookup_request,
    input  dcache_pkg::refill_t          refill,
    input  dcache_pkg::dcache_request_t  pending_store,
    input  logic                         flush_valid,
    input  logic [$clog2(num_lines)-1:0] flush_index,
    output logic                         hit,
    output mem_bus_pkg::mem_block_t      hit_block,
    output dcache_pkg::writeback_t       writeback
);
    localparam int index_bits = $clog2(num_lines);
    localparam int off = mem_bus_pkg::block_offset_bits;
    localparam int xlen = mem_bus_pkg::xlen;

    dcache_pkg::cache_line_t lines [num_lines];
    logic [index_bits-1:0] lookup_index;
    logic [index_bits-1:0] refill_index;
    logic [index_bits-1:0] victim_index;
    dcache_pkg::cache_line_t victim;
    logic store_hit;
    logic pending_merge;

    assign lookup_index = lookup_request.addr[off +: index_bits];
    assign refill_index = refill.line_addr[index_bits-1:0];

    assign hit = lookup_request.valid && lines[lookup_index].valid
                 && lines[lookup_index].line_addr == lookup_request.addr[xlen-1:off];
    assign hit_block = lines[lookup_index].block;
    assign store_hit = hit && lookup_request.mem_op == dcache_pkg::mem_write;

    // a store miss lands in the refilled line
    assign pending_merge = refill.valid && pending_store.valid
                           && pending_store.mem_op == dcache_pkg::mem_write
                           && pending_store.addr[xlen-1:off] == refill.line_addr;

    // refill and flush sweep never happen together
    assign victim_index = refill.valid ? refill_index : flush_index;
    assign victim = lines[victim_index];

    always_comb begin
        writeback = '0;
        if ((refill.valid || flush_valid) && victim.valid && victim.dirty) begin
            writeback.valid     = 1'b1;
            writeback.line_addr = victim.line_addr;
            writeback.block     = victim.block;
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            for (int i = 0; i < num_lines; i++) begin
                lines[i].valid <= 1'b0;
                lines[i].dirty <= 1'b0;
            end
        end else begin
            if (store_hit) begin
                lines[lookup_index].block <= dcache_pkg::merge_data(lines[lookup_index].block,
                    lookup_request.size, lookup_request.addr[off-1:0],
                    lookup_request.write_data);
                lines[lookup_index].dirty <= 1'b1;
            end
            if (refill.valid) begin
                lines[refill_index].valid     <= 1'b1;
                lines[refill_index].dirty     <= pending_merge;
                lines[refill_index].line_addr <= refill.line_addr;
                lines[refill_index].block     <= pending_merge
                    ? dcache_pkg::merge_data(refill.block, pending_store.size,
                                             pending_store.addr[off-1:0],
                                             pending_store.write_data)
                    : refill.block;
            end
            if (flush_valid)
                lines[flush_index].dirty <= 1'b0; // copy now sits in the MSHR table
        end
    end

    // the line being refilled was a miss, so nothing can hit it yet
    no_hit_on_refill: assert property (@(posedge clock) disable iff (reset)
        refill.valid |-> !(hit && lookup_index == refill_index));

endmodule

// ==== source/mshr_table.sv ====
`timescale 1ns/1ps

module mshr_table #(
    parameter int num_mshr = 4
) (
    input  logic                           clock,
    input  logic                           reset,
    input  logic                           miss_alloc,
    input  mem_bus_pkg::mem_addr_t         miss_line_addr,
    input  dcache_pkg::writeback_t         writeback,
    input  mem_bus_pkg::mem_tag_t          mem2proc_response,
    input  mem_bus_pkg::mem_tag_t          mem2proc_tag,
    input  mem_bus_pkg::mem_block_t        mem2proc_data,
    output mem_bus_pkg::bus_command_t      proc2mem_command,
    output mem_bus_pkg::mem_addr_t         proc2mem_addr,
    output mem_bus_pkg::mem_block_t        proc2mem_data,
    output dcache_pkg::refill_t            refill,
    output logic [$clog2(num_mshr+1)-1:0]  free_count,
    output logic                           empty
);
    localparam int slot_bits = $clog2(num_mshr);
    localparam int count_bits = $clog2(num_mshr + 1);
    localparam int off = mem_bus_pkg::block_offset_bits;

    dcache_pkg::mshr_entry_t entries [num_mshr];
    dcache_pkg::mshr_entry_t new_entry;
    logic [slot_bits-1:0] free_slot, write_slot, read_slot, issue_slot, match_slot;
    logic has_free, write_found, read_found, issue_valid, accepted;
    logic match_valid;
    logic [count_bits-1:0] free_total;

    // scan from the top down so the lowest index wins
    always_comb begin
        has_free      = 1'b0;
        free_slot     = '0;
        write_found   = 1'b0;
        write_slot    = '0;
        read_found    = 1'b0;
        read_slot     = '0;
        match_valid   = 1'b0;
        match_slot    = '0;
        free_total    = '0;
        for (int i = num_mshr - 1; i >= 0; i--) begin
            if (!entries[i].valid) begin
                has_free   = 1'b1;
                free_slot  = slot_bits'(i);
                free_total = free_total + 1'b1;
            end else if (!entries[i].issued) begin
                if (entries[i].mem_op == dcache_pkg::mem_write) begin
                    write_found = 1'b1;
                    write_slot  = slot_bits'(i);
                end else begin
                    read_found = 1'b1;
                    read_slot  = slot_bits'(i);
                end
            end
            // only reads stay issued, writes leave at acceptance
            if (entries[i].valid && entries[i].issued && mem2proc_tag != '0
                && entries[i].mem_tag == mem2proc_tag) begin
                match_valid = 1'b1;
                match_slot  = slot_bits'(i);
            end
        end
    end

    // writebacks go out ahead of the read
    assign issue_valid = write_found || read_found;
    assign issue_slot = write_found ? write_slot : read_slot;
    assign accepted = issue_valid && mem2proc_response != '0;

    assign proc2mem_command = !issue_valid ? mem_bus_pkg::bus_none
        : (entries[issue_slot].mem_op == dcache_pkg::mem_write) ? mem_bus_pkg::bus_store
                                                                : mem_bus_pkg::bus_load;
    assign proc2mem_addr = {entries[issue_slot].line_addr, {off{1'b0}}};
    assign proc2mem_data = entries[issue_slot].block;

    assign refill.valid     = match_valid;
    assign refill.line_addr = entries[match_slot].line_addr;
    assign refill.block     = mem2proc_data;

    assign free_count = free_total;
    assign empty = free_total == count_bits'(num_mshr);

    always_comb begin
        new_entry = '0;
        new_entry.valid = 1'b1;
        if (writeback.valid) begin
            new_entry.mem_op    = dcache_pkg::mem_write;
            new_entry.line_addr = writeback.line_addr;
            new_entry.block     = writeback.block;
        end else begin
            new_entry.mem_op    = dcache_pkg::mem_read;
            new_entry.line_addr = miss_line_addr[mem_bus_pkg::xlen-1:off];
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            for (int i = 0; i < num_mshr; i++) begin
                entries[i].valid  <= 1'b0;
                entries[i].issued <= 1'b0;
            end
        end else begin
            if (accepted) begin
                if (entries[issue_slot].mem_op == dcache_pkg::mem_write) begin
                    entries[issue_slot].valid <= 1'b0; // nothing comes back for a store
                end else begin
                    entries[issue_slot].issued  <= 1'b1;
                    entries[issue_slot].mem_tag <= mem2proc_response;
                end
            end
            if (match_valid)
                entries[match_slot].valid <= 1'b0;
            if ((miss_alloc || writeback.valid) && has_free)
                entries[free_slot] <= new_entry;
        end
    end

    // a load response always lands on the issued read that holds its tag
    response_has_read: assert property (@(posedge clock) disable iff (reset)
        mem2proc_tag != '0 |-> match_valid);

    // the control keeps a spare entry for every eviction and flush
    writeback_has_room: assert property (@(posedge clock) disable iff (reset)
        writeback.valid |-> has_free);

endmodule

// ==== source/dcache.sv ====
`timescale 1ns/1ps

module dcache #(
    parameter int num_lines = 16,
    parameter int num_mshr = 4
) (
    input  logic                         clock,
    input  logic                         reset,
    input  dcache_pkg::dcache_request_t  dcache_request,
    output dcache_pkg::dcache_response_t dcache_response,
    output logic                         stall,
    input  logic                         done,
    output logic                         flush_finished,
    input  mem_bus_pkg::mem_tag_t        mem2proc_response,
    input  mem_bus_pkg::mem_block_t      mem2proc_data,
    input  mem_bus_pkg::mem_tag_t        mem2proc_tag,
    output mem_bus_pkg::bus_command_t    proc2mem_command,
    output mem_bus_pkg::mem_addr_t       proc2mem_addr,
    output mem_bus_pkg::mem_block_t      proc2mem_data
);
    localparam int count_bits = $clog2(num_mshr + 1);

    dcache_pkg::dcache_request_t lookup_request;
    dcache_pkg::refill_t refill;
    dcache_pkg::writeback_t writeback;
    mem_bus_pkg::mem_block_t hit_block;
    mem_bus_pkg::mem_addr_t miss_line_addr;
    logic [count_bits-1:0] free_count;
    logic [$clog2(num_lines)-1:0] flush_index;
    logic hit, miss_alloc, flush_valid, mshr_empty;

    dcache_control #(.num_lines(num_lines), .count_bits(count_bits)) i_control (
        .clock, .reset, .dcache_request, .done, .hit, .hit_block, .refill, .free_count,
        .mshr_empty, .lookup_request, .miss_alloc, .miss_line_addr, .flush_valid,
        .flush_index, .stall, .dcache_response, .flush_finished
    );

    // the lookup request doubles as the waiting store while a miss is open
    main_cache_array #(.num_lines(num_lines)) i_array (
        .clock, .reset, .lookup_request, .refill, .pending_store(lookup_request),
        .flush_valid, .flush_index, .hit, .hit_block, .writeback
    );

    mshr_table #(.num_mshr(num_mshr)) i_mshr (
        .clock, .reset, .miss_alloc, .miss_line_addr, .writeback, .mem2proc_response,
        .mem2proc_tag, .mem2proc_data, .proc2mem_command, .proc2mem_addr, .proc2mem_data,
        .refill, .free_count, .empty(mshr_empty)
    );

endmodule

// ==== tb/tb_mem_model.sv ====
`timescale 1ns/1ps

module tb_mem_model #(
    parameter int seed = 43
) (
    input  logic                      clock,
    input  logic                      reset,
    input  mem_bus_pkg::bus_command_t proc2mem_command,
    input  mem_bus_pkg::mem_addr_t    proc2mem_addr,
    input  mem_bus_pkg::mem_block_t   proc2mem_data,
    output mem_bus_pkg::mem_tag_t     mem2proc_response,
    output mem_bus_pkg::mem_tag_t     mem2proc_tag,
    output mem_bus_pkg::mem_block_t   mem2proc_data,
    input  mem_bus_pkg::mem_addr_t    peek_addr,
    output logic [31:0]               peek_word
);
    localparam int off = mem_bus_pkg::block_offset_bits;

    typedef logic [mem_bus_pkg::xlen-off-1:0] line_t;

    typedef struct packed {
        mem_bus_pkg::mem_tag_t   tag;
        mem_bus_pkg::mem_block_t block;
        logic [3:0]              wait_cycles;
    } pending_load_t;

    mem_bus_pkg::mem_block_t blocks [line_t]; // only lines that were stored
    pending_load_t pending [$];
    mem_bus_pkg::mem_tag_t next_tag = 4'd1;

    // every command is taken in the cycle it shows up
    assign mem2proc_response = (proc2mem_command == mem_bus_pkg::bus_none) ? '0 : next_tag;

    // untouched memory, every byte folds in all four address bytes
    function automatic mem_bus_pkg::mem_block_t initial_block(line_t line);
        mem_bus_pkg::mem_block_t block;
        mem_bus_pkg::mem_addr_t addr;
        for (int i = 0; i < mem_bus_pkg::block_bytes; i++) begin
            addr = {line, off'(i)};
            block[i*8 +: 8] = addr[7:0] ^ addr[15:8] ^ addr[23:16] ^ addr[31:24] ^ 8'h5a;
        end
        return block;
    endfunction

    function automatic mem_bus_pkg::mem_block_t read_block(line_t line);
        if (blocks.exists(line))
            return blocks[line];
        return initial_block(line);
    endfunction

    initial begin
        mem_bus_pkg::bus_command_t command;
        mem_bus_pkg::mem_addr_t addr;
        mem_bus_pkg::mem_addr_t peek;
        mem_bus_pkg::mem_block_t data;
        mem_bus_pkg::mem_block_t block;
        mem_bus_pkg::mem_tag_t tag;
        pending_load_t load;
        logic in_reset;
        void'($urandom(seed));
        mem2proc_tag = '0;
        mem2proc_data = '0;
        peek_word = '0;
        forever begin
            @(posedge clock);
            command  = proc2mem_command; // what the DUT sees at this edge
            addr     = proc2mem_addr;
            data     = proc2mem_data;
            tag      = mem2proc_response;
            peek     = peek_addr;
            in_reset = reset;
            #1;
            mem2proc_tag = '0;
            if (in_reset) begin
                pending.delete();
                next_tag = 4'd1;
            end else begin
                if (command == mem_bus_pkg::bus_store) begin
                    blocks[addr[mem_bus_pkg::xlen-1:off]] = data;
                end else if (command == mem_bus_pkg::bus_load) begin
                    load.tag         = tag;
                    load.block       = read_block(addr[mem_bus_pkg::xlen-1:off]);
                    load.wait_cycles = 4'($urandom_range(6, 3));
                    pending.push_back(load);
                end
                if (command != mem_bus_pkg::bus_none)
                    next_tag = (next_tag == 4'd15) ? 4'd1 : next_tag + 4'd1;
                for (int i = 0; i < pending.size(); i++) begin
                    if (pending[i].wait_cycles != 0)
                        pending[i].wait_cycles = pending[i].wait_cycles - 4'd1;
                end
                if (pending.size() > 0 && pending[0].wait_cycles == 0) begin
                    load = pending.pop_front(); // one response per cycle
                    mem2proc_tag  = load.tag;
                    mem2proc_data = load.block;
                end
            end
            block = read_block(peek[mem_bus_pkg::xlen-1:off]);
            peek_word = peek[2] ? block[63:32] : block[31:0];
        end
    end

endmodule

// ==== tb/tb_dcache.sv ====
`timescale 1ns/1ps

module tb_dcache;
    localparam int max_vectors = 64;
    localparam logic [3:0] kind_store = 4'h2;
    localparam logic [3:0] kind_check = 4'h3;

    typedef struct packed {
        logic [3:0]  kind;
        logic [3:0]  hit;   // 1 when the request must hit
        logic [3:0]  size;
        logic [31:0] addr;
        logic [31:0] write_data;
        logic [31:0] expected;
    } vector_t;

    logic clock = 1'b0;
    logic reset, done, stall, flush_finished;
    dcache_pkg::dcache_request_t dcache_request;
    dcache_pkg::dcache_response_t dcache_response;
    mem_bus_pkg::mem_tag_t mem2proc_response, mem2proc_tag;
    mem_bus_pkg::mem_block_t mem2proc_data, proc2mem_data;
    mem_bus_pkg::bus_command_t proc2mem_command;
    mem_bus_pkg::mem_addr_t proc2mem_addr, peek_addr;
    logic [31:0] peek_word;
    logic [$bits(vector_t)-1:0] vectors [max_vectors];
    int num_vectors = 0;
    int cycle_count = 0;
    int cycle_limit = 0;

    always #5 clock = ~clock;

    dcache #(.num_lines(16), .num_mshr(4)) i_dcache (
        .clock, .reset, .dcache_request, .dcache_response, .stall, .done, .flush_finished,
        .mem2proc_response, .mem2proc_data, .mem2proc_tag, .proc2mem_command,
        .proc2mem_addr, .proc2mem_data
    );

    tb_mem_model #(.seed(43)) i_mem (
        .clock, .reset, .proc2mem_command, .proc2mem_addr, .proc2mem_data,
        .mem2proc_response, .mem2proc_tag, .mem2proc_data, .peek_addr, .peek_word
    );

    always @(posedge clock) begin
        cycle_count++;
        if (cycle_limit > 0 && cycle_count > cycle_limit) begin
            $display("Timeout: the run did not finish within %0d cycles", cycle_limit);
            $display("Simulation failed");
            $fatal(1, "run stopped by the cycle limit");
        end
    end

    task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
                               input string what);
        if (actual !== expected) begin
            $display("Mismatch at %0t: %s, got %08h, expected %08h",
                     $time, what, actual, expected);
            $display("Simulation failed");
            $fatal(1, "value check failed");
        end
    endtask

    // called one ns after a rising edge, returns at the same phase
    task automatic run_request(input vector_t vec, input int number);
        string what;
        what = $sformatf("vector %0d at %08h", number, vec.addr);
        while (stall) begin
            @(posedge clock);
            #1;
        end
        dcache_request.valid      = 1'b1;
        dcache_request.mem_op     = (vec.kind == kind_store) ? dcache_pkg::mem_write
                                                             : dcache_pkg::mem_read;
        dcache_request.size       = dcache_pkg::mem_size_t'(vec.size[1:0]);
        dcache_request.addr       = vec.addr;
        dcache_request.write_data = vec.write_data;
        @(posedge clock);
        #1;
        dcache_request = '0;
        if (vec.hit[0]) begin
            check_value(32'(dcache_response.valid), 32'd1, {what, " hit response"});
            check_value(32'(stall), 32'd0, {what, " stall on a hit"});
        end else begin
            check_value(32'(stall), 32'd1, {what, " stall on a miss"});
            while (!dcache_response.valid) begin
                @(posedge clock);
                #1;
            end
        end
        check_value(dcache_response.reg_data, vec.expected, {what, " response data"});
    endtask

    task automatic flush_cache();
        while (stall) begin
            @(posedge clock);
            #1;
        end
        done = 1'b1;
        while (!flush_finished) begin
            @(posedge clock);
            #1;
        end
    endtask

    task automatic check_memory(input vector_t vec);
        peek_addr = vec.addr;
        repeat (2) @(posedge clock); // memory model picks up the address, then settles
        check_value(peek_word, vec.expected, $sformatf("memory word at %08h", vec.addr));
        #1;
    endtask

    initial begin
        vector_t vec;
        reset = 1'b1;
        done = 1'b0;
        dcache_request = '0;
        peek_addr = '0;
        for (int i = 0; i < max_vectors; i++)
            vectors[i] = '0;
        $readmemh("tb/dcache_input.txt", vectors);
        while (num_vectors < max_vectors && vectors[num_vectors] != '0)
            num_vectors++;
        if (num_vectors == 0) begin
            $display("No stimulus could be read from tb/dcache_input.txt");
            $display("Simulation failed");
            $fatal(1, "stimulus file empty or missing");
        end
        cycle_limit = 200 * num_vectors + 500;
        repeat (2) @(posedge clock);
        #1;
        reset = 1'b0;
        check_value(32'(stall), 32'd0, "stall after reset");
        check_value(32'(dcache_response.valid), 32'd0, "response valid after reset");
        check_value(32'(proc2mem_command), 32'(mem_bus_pkg::bus_none), "bus command after reset");
        check_value(32'(flush_finished), 32'd0, "flush_finished after reset");
        for (int i = 0; i < num_vectors; i++) begin
            vec = vector_t'(vectors[i]);
            if (vec.kind == kind_check) begin
                if (!done)
                    flush_cache(); // checks read memory only after the flush
                check_memory(vec);
            end else begin
                run_request(vec, i);
            end
        end
        if (!done)
            flush_cache();
        $display("Simulation completed successfully");
        $finish;
    end

endmodule

// ==== tb/dcache_input.txt ====
// kind (1 load, 2 store, 3 memory word after flush), hit (1 must hit), size (0 byte, 1 half, 2 word)
// then address, write data, expected data; memory checks leave hit, size and write data zero
1_0_0_00000100_00000000_0000005b
1_1_1_00000102_00000000_00005859
1_0_0_000001a5_00000000_000000fe
1_0_1_000002ce_00000000_00009796
1_0_2_000003f0_00000000_aaaba8a9
1_1_0_000003f7_00000000_000000ae
2_1_0_00000101_000000c3_00000000
1_1_2_00000100_00000000_5859c35b
2_1_1_00000106_0000beef_00000000
1_1_2_00000104_00000000_beef5e5f
2_0_0_00000043_000000a7_00000000
1_1_2_00000040_00000000_a7181b1a
1_0_2_00000180_00000000_d8d9dadb
1_0_2_00000100_00000000_5859c35b
1_1_2_00000104_00000000_beef5e5f
2_1_2_000003f4_cafef00d_00000000
3_0_0_00000040_00000000_a7181b1a
3_0_0_000003f4_00000000_cafef00d
3_0_0_00000100_00000000_5859c35b
3_0_0_00000104_00000000_beef5e5f
3_0_0_000003f0_00000000_aaaba8a9
3_0_0_00000184_00000000_dcdddedf

// ==== dcache.f ====
source/mem_bus_pkg.sv
source/dcache_pkg.sv
source/dcache_control.sv
source/main_cache_array.sv
source/mshr_table.sv
source/dcache.sv
tb/tb_mem_model.sv
tb/tb_dcache.sv

// ==== Makefile ====
VERILATOR    ?= verilator
TOP          := tb_dcache
RTL_TOP      := dcache
FILELIST     := dcache.f
BUILD_DIR    := obj_dir
LOG          := sim.log
PASS_TEXT    := Simulation completed successfully
COMMON_FLAGS := --timescale 1ns/1ps --timing -f $(FILELIST)
LINT_FLAGS   := --lint-only -Wall
SIM_FLAGS    := --binary --assert -j 0 --Mdir $(BUILD_DIR)

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) $(COMMON_FLAGS) --top-module $(RTL_TOP)

sim:
	$(VERILATOR) $(SIM_FLAGS) $(COMMON_FLAGS) --top-module $(TOP)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "$(PASS_TEXT)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
